/* vlog.f */
design/mmuPkg.sv
design/cp0RegPkg.sv
design/tlbLookup.sv
design/tlbArray.sv
design/cp0TlbRegs.sv
design/mmuTop.sv
dv/tbMmuTop.sv

/* Bender.yml */
package:
  name: mmu_tlb

sources:
  - files:
      - design/mmuPkg.sv
      - design/cp0RegPkg.sv
      - design/tlbLookup.sv
      - design/tlbArray.sv
      - design/cp0TlbRegs.sv
      - design/mmuTop.sv
  - target: test
    files:
      - dv/tbMmuTop.sv

/* dv/tbMmuTop.sv */
`timescale 1ns/1ps

module tbMmuTop
  import mmuPkg::*;
  import cp0RegPkg::*;
();

  localparam int TimeoutCycles = 4000;

  logic clk, rst_n, pSel, pEnable, pWrite, pReady, pSlverr;
  logic [4:0]  pAddr;
  logic [31:0] pWdata, pRdata, insVirt, dataVirt, insPhy, dataPhy;
  logic insMiss, insValid, insDirty, dataMiss, dataValid, dataDirty;

  // Reference copy of the TLB contents.
  logic [Vpn2W-1:0] mVpn2 [NumEntries];
  logic             mG    [NumEntries];
  logic [AsidW-1:0] mAsid [NumEntries];
  logic [LoW-1:0]   mLo0  [NumEntries];
  logic [LoW-1:0]   mLo1  [NumEntries];
  logic [AsidW-1:0] mCurAsid;
  logic [AsidW-1:0] baseAsid;
  int seed   = 47;
  int cycles = 0;

  mmuTop i_dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run went past %0d clock cycles.", TimeoutCycles);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped by watchdog.");
    end
  end

  task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Stopping at first mismatch.");
    end
  endtask

  function automatic logic [31:0] hiWord(input logic [Vpn2W-1:0] vpn2, input logic g,
                                         input logic [AsidW-1:0] asid);
    return {vpn2, g, 4'b0, asid};
  endfunction

  // Setup cycle and access cycle with outputs sampled mid-cycle.
  task automatic apbAccess(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                           input logic expErr, output logic [31:0] rdata);
    @(negedge clk);
    pSel    = 1'b1;
    pEnable = 1'b0;
    pWrite  = wr;
    pAddr   = addr;
    pWdata  = wdata;
    @(negedge clk);
    pEnable = 1'b1;
    #1;
    expectEq("pReady", 32'h1, pReady);
    expectEq("pSlverr", expErr, pSlverr);
    rdata = pRdata;
    @(negedge clk);
    pSel    = 1'b0;
    pEnable = 1'b0;
  endtask

  task automatic apbWrite(input logic [4:0] addr, input logic [31:0] data, input logic expErr);
    logic [31:0] unused;
    apbAccess(1'b1, addr, data, expErr, unused);
  endtask

  task automatic apbRead(input logic [4:0] addr, output logic [31:0] data, input logic expErr);
    apbAccess(1'b0, addr, 32'h0, expErr, data);
  endtask

  task automatic refLookup(input logic [31:0] va, output logic miss, output logic [31:0] phy,
                           output logic v, output logic d, output logic [IdxW-1:0] idx);
    logic [LoW-1:0] lo;
    miss = 1'b1;
    phy  = '0;
    v    = 1'b0;
    d    = 1'b0;
    idx  = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin  // Ends on the lowest match.
      if (mVpn2[i] == va[31:13] && (mG[i] || mAsid[i] == mCurAsid)) begin
        miss = 1'b0;
        idx  = IdxW'(i);
      end
    end
    if (!miss) begin
      lo  = va[12] ? mLo1[idx] : mLo0[idx];
      phy = {lo[21:2], va[11:0]};
      v   = lo[0];
      d   = lo[1];
    end
  endtask

  task automatic translate(input logic [31:0] iva, input logic [31:0] dva);
    logic m, v, d;
    logic [31:0] p;
    logic [IdxW-1:0] x;
    @(negedge clk);
    insVirt  = iva;
    dataVirt = dva;
    #1;
    refLookup(iva, m, p, v, d, x);
    expectEq("insPhy", p, insPhy);
    expectEq("insMiss", m, insMiss);
    expectEq("insValid", v, insValid);
    expectEq("insDirty", d, insDirty);
    refLookup(dva, m, p, v, d, x);
    expectEq("dataPhy", p, dataPhy);
    expectEq("dataMiss", m, dataMiss);
    expectEq("dataValid", v, dataValid);
    expectEq("dataDirty", d, dataDirty);
  endtask

  // Non-zero VPN2 that is not yet in the table.
  task automatic newVpn2(output logic [Vpn2W-1:0] v);
    logic used;
    do begin
      v    = $random(seed);
      used = 1'b0;
      for (int i = 0; i < NumEntries; i++) used |= (mVpn2[i] == v);
    end while (v == 0 || used);
  endtask

  task automatic setEntryHi(input logic [Vpn2W-1:0] vpn2, input logic g,
                            input logic [AsidW-1:0] asid);
    apbWrite(RegEntryHi, hiWord(vpn2, g, asid), 1'b0);
    mCurAsid = asid;
  endtask

  task automatic tlbWrite(input int idx, input logic [Vpn2W-1:0] vpn2, input logic g,
                          input logic [AsidW-1:0] asid, input logic [LoW-1:0] lo0,
                          input logic [LoW-1:0] lo1);
    apbWrite(RegIndex, idx, 1'b0);
    apbWrite(RegEntryLo0, lo0, 1'b0);
    apbWrite(RegEntryLo1, lo1, 1'b0);
    setEntryHi(vpn2, g, asid);
    apbWrite(RegCommand, OpTlbwi, 1'b0);
    mVpn2[idx] = vpn2;
    mG[idx]    = g;
    mAsid[idx] = asid;
    mLo0[idx]  = lo0;
    mLo1[idx]  = lo1;
  endtask

  task automatic tlbRead(input int idx);
    logic [31:0] rd;
    apbWrite(RegIndex, idx, 1'b0);
    apbWrite(RegCommand, OpTlbr, 1'b0);
    mCurAsid = mAsid[idx];  // EntryHi now holds the read ASID.
    apbRead(RegEntryLo0, rd, 1'b0);
    expectEq("EntryLo0", mLo0[idx], rd);
    apbRead(RegEntryLo1, rd, 1'b0);
    expectEq("EntryLo1", mLo1[idx], rd);
    apbRead(RegEntryHi, rd, 1'b0);
    expectEq("EntryHi", hiWord(mVpn2[idx], mG[idx], mAsid[idx]), rd);
  endtask

  task automatic tlbProbe(input logic [Vpn2W-1:0] vpn2, output logic [31:0] index);
    setEntryHi(vpn2, 1'b0, baseAsid);
    apbWrite(RegCommand, OpTlbp, 1'b0);
    apbRead(RegIndex, index, 1'b0);
  endtask

  task automatic testReset();
    logic [31:0] rd;
    logic [Vpn2W-1:0] v;
    apbRead(RegIndex, rd, 1'b0);
    expectEq("Index", 32'h0, rd);
    apbRead(RegEntryLo0, rd, 1'b0);
    expectEq("EntryLo0", 32'h0, rd);
    apbRead(RegEntryLo1, rd, 1'b0);
    expectEq("EntryLo1", 32'h0, rd);
    apbRead(RegEntryHi, rd, 1'b0);
    expectEq("EntryHi", 32'h0, rd);
    newVpn2(v);
    translate({v, 13'h0abc}, {v, 13'h1123});
    expectEq("insMiss", 32'h1, insMiss);
    expectEq("dataMiss", 32'h1, dataMiss);
  endtask

  task automatic testFill();
    logic [Vpn2W-1:0] v;
    logic [11:0] off;
    baseAsid = $random(seed);
    for (int i = 0; i < NumEntries; i++) begin
      newVpn2(v);
      tlbWrite(i, v, 1'b0, baseAsid, LoW'($random(seed)), LoW'($random(seed)));
    end
    for (int i = 0; i < NumEntries; i++) begin
      off = $random(seed);
      translate({mVpn2[i], 1'b0, off}, {mVpn2[i], 1'b1, off});
      translate({mVpn2[i], 1'b1, ~off}, {mVpn2[i], 1'b0, ~off});
    end
  endtask

  task automatic testAsid();
    // Entry 15 becomes a global alias of entry 3.
    tlbWrite(15, mVpn2[3], 1'b1, baseAsid, LoW'($random(seed)), LoW'($random(seed)));
    translate({mVpn2[3], 13'h0010}, {mVpn2[3], 13'h1010});
    setEntryHi(mVpn2[0], 1'b0, baseAsid ^ 8'ha5);
    for (int i = 0; i < NumEntries; i++) begin
      translate({mVpn2[i], 13'h0044}, {mVpn2[i], 13'h1044});
    end
    translate({mVpn2[3], 13'h0200}, {mVpn2[0], 13'h0200});
    expectEq("insMiss", 32'h0, insMiss);
    expectEq("dataMiss", 32'h1, dataMiss);
    setEntryHi(mVpn2[0], 1'b0, baseAsid);
  endtask

  task automatic testProbe();
    logic [31:0] rd, p;
    logic m, v, d;
    logic [IdxW-1:0] x;
    logic [Vpn2W-1:0] absent;
    for (int i = 0; i < NumEntries; i++) begin
      tlbProbe(mVpn2[i], rd);
      refLookup({mVpn2[i], 13'h0}, m, p, v, d, x);
      expectEq("Index", {28'h0, x}, rd);
    end
    newVpn2(absent);
    tlbProbe(absent, rd);
    expectEq("Index[31]", 32'h1, rd[31]);
  endtask

  task automatic testReadBack();
    for (int i = 0; i < NumEntries; i++) tlbRead(i);
  endtask

  task automatic testErrors();
    logic [31:0] rd;
    apbRead(5'h14, rd, 1'b1);
    apbWrite(5'h1c, 32'hffff_ffff, 1'b1);
    apbWrite(RegCommand, OpTlbp, 1'b0);
    apbRead(RegCommand, rd, 1'b0);
    expectEq("Command", 32'h0, rd);
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    pSel     = 1'b0;
    pEnable  = 1'b0;
    pWrite   = 1'b0;
    pAddr    = '0;
    pWdata   = '0;
    insVirt  = '0;
    dataVirt = '0;
    mCurAsid = '0;
    baseAsid = '0;
    for (int i = 0; i < NumEntries; i++) begin
      mVpn2[i] = '0;
      mG[i]    = 1'b0;
      mAsid[i] = '0;
      mLo0[i]  = '0;
      mLo1[i]  = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    testReset();
    testFill();
    testAsid();
    testProbe();
    testReadBack();
    testErrors();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* design/mmuTop.sv */
`timescale 1ns/1ps

module mmuTop
  import mmuPkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pSel,
  input  logic        pEnable,
  input  logic        pWrite,
  input  logic [4:0]  pAddr,
  input  logic [31:0] pWdata,
  output logic [31:0] pRdata,
  output logic        pReady,
  output logic        pSlverr,
  input  logic [31:0] insVirt,
  input  logic [31:0] dataVirt,
  output logic [31:0] insPhy,
  output logic        insMiss,
  output logic        insValid,
  output logic        insDirty,
  output logic [31:0] dataPhy,
  output logic        dataMiss,
  output logic        dataValid,
  output logic        dataDirty
);

  logic [EntryW-1:0] stageEntry;
  logic [EntryW-1:0] readEntry;
  logic [IdxW-1:0]   entryIdx;
  logic              entryWrite;
  logic [Vpn2W-1:0]  probeVpn2;
  logic [AsidW-1:0]  curAsid;
  logic              probeMiss;
  logic [IdxW-1:0]   probeIdx;

  cp0TlbRegs regs (
    .clk, .rst_n, .pSel, .pEnable, .pWrite, .pAddr, .pWdata, .pRdata, .pReady,
    .pSlverr, .stageEntry, .entryIdx, .entryWrite, .readEntry, .probeVpn2,
    .curAsid, .probeMiss, .probeIdx
  );

  tlbArray array (
    .clk, .rst_n, .entryWrite, .entryIdx, .stageEntry, .readEntry, .curAsid,
    .probeVpn2, .probeMiss, .probeIdx, .insVirt, .dataVirt, .insPhy, .insMiss,
    .insValid, .insDirty, .dataPhy, .dataMiss, .dataValid, .dataDirty
  );

endmodule

/* design/cp0TlbRegs.sv */
`timescale 1ns/1ps

module cp0TlbRegs
  import mmuPkg::*;
  import cp0RegPkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pSel,
  input  logic              pEnable,
  input  logic              pWrite,
  input  logic [4:0]        pAddr,
  input  logic [31:0]       pWdata,
  output logic [31:0]       pRdata,
  output logic              pReady,
  output logic              pSlverr,
  output logic [EntryW-1:0] stageEntry,
  output logic [IdxW-1:0]   entryIdx,
  output logic              entryWrite,
  input  logic [EntryW-1:0] readEntry,
  output logic [Vpn2W-1:0]  probeVpn2,
  output logic [AsidW-1:0]  curAsid,
  input  logic              probeMiss,
  input  logic [IdxW-1:0]   probeIdx
);

  regAddrE          addr;
  tlbOpE            cmdOp;
  logic             access;
  logic             addrOk;
  logic             wrEn;
  logic [IdxW-1:0]  idx;
  logic             probeFail;
  logic [LoW-1:0]   lo0;
  logic [LoW-1:0]   lo1;
  logic [Vpn2W-1:0] hiVpn2;
  logic             hiG;
  logic [AsidW-1:0] hiAsid;

  assign addr   = regAddrE'(pAddr);
  assign access = pSel & pEnable;

  always_comb begin
    case (addr)
      RegIndex, RegEntryLo0, RegEntryLo1, RegEntryHi, RegCommand: addrOk = 1'b1;
      default: addrOk = 1'b0;
    endcase
  end

  assign pReady  = access;  // No wait states.
  assign pSlverr = access & ~addrOk;
  assign wrEn    = access & pWrite & addrOk;
  assign cmdOp   = (wrEn && addr == RegCommand) ? tlbOpE'(pWdata[1:0]) : OpNone;

  // Array latches the staged entry on the edge ending the access.
  assign entryWrite = (cmdOp == OpTlbwi);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx       <= '0;
      probeFail <= 1'b0;
      lo0       <= '0;
      lo1       <= '0;
      hiVpn2    <= '0;
      hiG       <= 1'b0;
      hiAsid    <= '0;
    end else begin
      if (wrEn) begin
        case (addr)
          RegIndex:    idx <= pWdata[IdxW-1:0];
          RegEntryLo0: lo0 <= pWdata[LoW-1:0];
          RegEntryLo1: lo1 <= pWdata[LoW-1:0];
          RegEntryHi: begin
            hiVpn2 <= pWdata[HiVpn2Lsb +: Vpn2W];
            hiG    <= pWdata[HiGBit];
            hiAsid <= pWdata[AsidW-1:0];
          end
          default: ;
        endcase
      end
      if (cmdOp == OpTlbr) begin
        hiAsid <= readEntry[AsidLsb +: AsidW];
        hiG    <= readEntry[GBit];
        hiVpn2 <= readEntry[Vpn2Lsb +: Vpn2W];
        lo1    <= readEntry[V1Bit +: LoW];
        lo0    <= readEntry[V0Bit +: LoW];
      end
      if (cmdOp == OpTlbp) begin
        idx       <= probeIdx;
        probeFail <= probeMiss;
      end
    end
  end

  always_comb begin
    pRdata = '0;
    case (addr)
      RegIndex: begin
        pRdata[ProbeFailBit] = probeFail;
        pRdata[IdxW-1:0]     = idx;
      end
      RegEntryLo0: pRdata[LoW-1:0] = lo0;
      RegEntryLo1: pRdata[LoW-1:0] = lo1;
      RegEntryHi: begin
        pRdata[HiVpn2Lsb +: Vpn2W] = hiVpn2;
        pRdata[HiGBit]             = hiG;
        pRdata[AsidW-1:0]          = hiAsid;
      end
      default: ;  // Command reads zero.
    endcase
  end

  always_comb begin
    stageEntry                      = '0;
    stageEntry[AsidLsb +: AsidW]    = hiAsid;
    stageEntry[GBit]                = hiG;
    stageEntry[Vpn2Lsb +: Vpn2W]    = hiVpn2;
    stageEntry[V1Bit +: LoW]        = lo1;
    stageEntry[V0Bit +: LoW]        = lo0;
  end

  assign entryIdx  = idx;
  assign probeVpn2 = hiVpn2;
  assign curAsid   = hiAsid;  // Current ASID lives in EntryHi.

endmodule

/* design/tlbArray.sv */
`timescale 1ns/1ps

module tlbArray
  import mmuPkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              entryWrite,
  input  logic [IdxW-1:0]   entryIdx,
  input  logic [EntryW-1:0] stageEntry,
  output logic [EntryW-1:0] readEntry,
  input  logic [AsidW-1:0]  curAsid,
  input  logic [Vpn2W-1:0]  probeVpn2,
  output logic              probeMiss,
  output logic [IdxW-1:0]   probeIdx,
  input  logic [31:0]       insVirt,
  input  logic [31:0]       dataVirt,
  output logic [31:0]       insPhy,
  output logic              insMiss,
  output logic              insValid,
  output logic              insDirty,
  output logic [31:0]       dataPhy,
  output logic              dataMiss,
  output logic              dataValid,
  output logic              dataDirty
);

  logic [EntryW-1:0] entries [NumEntries];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NumEntries; i++) begin
        entries[i] <= '0;
      end
    end else if (entryWrite) begin
      entries[entryIdx] <= stageEntry;
    end
  end

  assign readEntry = entries[entryIdx];  // Feeds TLBR.

  tlbLookup lookupIns (
    .virtAddr (insVirt),
    .entries  (entries),
    .curAsid  (curAsid),
    .phyAddr  (insPhy),
    .miss     (insMiss),
    .valid    (insValid),
    .dirty    (insDirty),
    .matchIdx ()
  );

  tlbLookup lookupData (
    .virtAddr (dataVirt),
    .entries  (entries),
    .curAsid  (curAsid),
    .phyAddr  (dataPhy),
    .miss     (dataMiss),
    .valid    (dataValid),
    .dirty    (dataDirty),
    .matchIdx ()
  );

  // Probe only needs the match, so the page offset and odd bit are zero.
  tlbLookup lookupProbe (
    .virtAddr ({probeVpn2, {(PageOffW + 1){1'b0}}}),
    .entries  (entries),
    .curAsid  (curAsid),
    .phyAddr  (),
    .miss     (probeMiss),
    .valid    (),
    .dirty    (),
    .matchIdx (probeIdx)
  );

endmodule

/* design/tlbLookup.sv */
`timescale 1ns/1ps

module tlbLookup
  import mmuPkg::*;
(
  input  logic [31:0]       virtAddr,
  input  logic [EntryW-1:0] entries [NumEntries],
  input  logic [AsidW-1:0]  curAsid,
  output logic [31:0]       phyAddr,
  output logic              miss,
  output logic              valid,
  output logic              dirty,
  output logic [IdxW-1:0]   matchIdx
);

  logic [NumEntries-1:0] hit;
  logic [EntryW-1:0]     winner;
  logic                  odd;
  logic [PfnW-1:0]       pfn;
  logic                  halfV;
  logic                  halfD;

  // Parallel compare of every entry.
  always_comb begin
    for (int i = 0; i < NumEntries; i++) begin
      hit[i] = (entries[i][Vpn2Lsb +: Vpn2W] == virtAddr[31:Vpn2AddrLsb]) &&
               (entries[i][GBit] || (entries[i][AsidLsb +: AsidW] == curAsid));
    end
  end

  // Lowest index wins.
  always_comb begin
    matchIdx = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (hit[i]) begin
        matchIdx = IdxW'(i);
      end
    end
  end

  assign miss   = ~|hit;
  assign winner = entries[matchIdx];
  assign odd    = virtAddr[OddBit];

  always_comb begin
    if (odd) begin
      pfn   = winner[Pfn1Lsb +: PfnW];
      halfV = winner[V1Bit];
      halfD = winner[D1Bit];
    end else begin
      pfn   = winner[Pfn0Lsb +: PfnW];
      halfV = winner[V0Bit];
      halfD = winner[D0Bit];
    end
  end

  // Zero result on a miss.
  always_comb begin
    if (miss) begin
      phyAddr = '0;
      valid   = 1'b0;
      dirty   = 1'b0;
    end else begin
      phyAddr = {pfn[PpnW-1:0], virtAddr[PageOffW-1:0]};
      valid   = halfV;
      dirty   = halfD;
    end
  end

endmodule

/* design/cp0RegPkg.sv */
package cp0RegPkg;

  // APB register map.
  typedef enum logic [4:0] {
    RegIndex    = 5'h00,
    RegEntryLo0 = 5'h04,
    RegEntryLo1 = 5'h08,
    RegEntryHi  = 5'h0C,
    RegCommand  = 5'h10
  } regAddrE;

  typedef enum logic [1:0] {
    OpNone  = 2'd0,
    OpTlbr  = 2'd1,
    OpTlbwi = 2'd2,
    OpTlbp  = 2'd3
  } tlbOpE;

  // Register bit positions.
  localparam int ProbeFailBit = 31;
  localparam int HiVpn2Lsb    = 13;
  localparam int HiGBit       = 12;

endpackage

/* design/mmuPkg.sv */
package mmuPkg;

  localparam int NumEntries = 16;
  localparam int IdxW       = 4;
  localparam int Vpn2W      = 19;
  localparam int PfnW       = 24;
  localparam int PpnW       = 20;  // Low PFN bits that reach the bus.
  localparam int AsidW      = 8;
  localparam int PageOffW   = 12;
  localparam int EntryW     = 80;

  // PFN, D and V of one page half.
  localparam int LoW = PfnW + 2;

  // Packed entry fields from low to high.
  localparam int V0Bit   = 0;
  localparam int D0Bit   = 1;
  localparam int Pfn0Lsb = 2;
  localparam int V1Bit   = 26;
  localparam int D1Bit   = 27;
  localparam int Pfn1Lsb = 28;
  localparam int Vpn2Lsb = 52;
  localparam int GBit    = 71;
  localparam int AsidLsb = 72;

  // Virtual address split.
  localparam int OddBit      = 12;  // Picks the odd page.
  localparam int Vpn2AddrLsb = 13;

endpackage
